// File: usiCore.f
logic/usiPkg.sv
logic/usiBus.sv
logic/gpioBlock.sv
logic/sysTimerBlock.sv
logic/pulseGen.sv
logic/usiCoreTop.sv
bench/tbUsiCore.sv

// File: run.sh
#!/bin/sh
# Build and run the USI core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tbUsiCore \
	-f usiCore.f

# Keep the output even when the simulation exits with an error
simOut=$(./obj_dir/VtbUsiCore) || true
echo "$simOut"

if echo "$simOut" | grep -q "TB PASSED"; then
	exit 0
else
	exit 1
fi

// File: bench/tbUsiCore.sv
// USI core testbench
// Host side bus master with back-pressure, checks of the GPIO, timer,
// unmapped blocks, heartbeat and PLL lock alternate sources
`timescale 1ns/1ns

module tbUsiCore;
	import usiPkg::*;

	localparam int WAIT_LIMIT = 50;	// Cycles per handshake wait

	logic        iMCLK;
	logic        qnARST;
	logic        iCmdValid;
	logic        iCmdWrite;
	logic [31:0] iCmdAdrs;
	logic [31:0] iCmdWd;
	logic        oCmdReady;
	logic        oRspValid;
	logic [31:0] oRspRd;
	logic        iRspReady;
	logic [5:0]  oGpio;
	logic [5:0]  oGpioDir;
	logic [5:0]  iGpioIn;
	logic        iPllLocked;

	int errCnt = 0;
	int checkCnt = 0;
	int cycleCnt = 0;
	bit hbCheck = 1'b0;	// Heartbeat watch window
	bit hbPrev = 1'b0;
	bit hbSeen = 1'b0;
	int hbGap = 0;
	int hbHighs = 0;

	usiCoreTop #(.pGpioWidth(6), .pHeartbeatDiv(20)) u_dut (
		.iMCLK(iMCLK),          .qnARST(qnARST),
		.iCmdValid(iCmdValid),  .iCmdWrite(iCmdWrite),
		.iCmdAdrs(iCmdAdrs),    .iCmdWd(iCmdWd),      .oCmdReady(oCmdReady),
		.oRspValid(oRspValid),  .oRspRd(oRspRd),      .iRspReady(iRspReady),
		.oGpio(oGpio),          .oGpioDir(oGpioDir),
		.iGpioIn(iGpioIn),      .iPllLocked(iPllLocked)
	);

	initial iMCLK = 1'b0;
	always #50 iMCLK = ~iMCLK;	// 100 ns period

	always @(posedge iMCLK) cycleCnt++;

	// ------------------------------
	// Checkers
	// ------------------------------
	task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
		checkCnt++;
		assert (got === exp)
		else
		begin
			errCnt++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkTrue(input string what, input bit cond);
		checkCnt++;
		assert (cond)
		else
		begin
			errCnt++;
			$display("Mismatch at %0t: %s does not hold", $time, what);
		end
	endtask

	task automatic timeoutReport(input string what);
		errCnt++;
		$display("Timeout at %0t: %s", $time, what);
	endtask

	// Stalled response must hold and keep the host blocked
	assert property (@(posedge iMCLK) disable iff (!qnARST)
		(oRspValid && !iRspReady) |=> (oRspValid && !oCmdReady && $stable(oRspRd)))
	else
	begin
		errCnt++;
		$display("Mismatch at %0t: read response moved while stalled", $time);
	end

	// Heartbeat pin, one cycle high then 19 low
	always @(negedge iMCLK)
	begin
		if (hbCheck)
		begin
			if (oGpio[1])
			begin
				checkTrue("heartbeat high for one cycle", !hbPrev);
				if (hbSeen && !hbPrev)
					checkEq("heartbeat gap", hbGap, 32'd19);
				hbSeen = 1'b1;
				hbGap = 0;
				hbHighs++;
			end
			else
				hbGap++;
			hbPrev = oGpio[1];
		end
		else
		begin
			hbSeen = 1'b0;
			hbPrev = 1'b0;
		end
	end

	// ------------------------------
	// Bus access
	// ------------------------------
	function automatic logic [31:0] csrAdrs(input logic [2:0] blk, input logic [7:0] ofs);
		logic [31:0] adrs;
		adrs = '0;
		adrs[CSR_ADRS_WIDTH +: BLOCK_ADRS_WIDTH] = blk;	// Block above the CSR space
		adrs[7:0] = ofs;
		return adrs;
	endfunction

	task automatic busWrite(input logic [31:0] adrs, input logic [31:0] data);
		int waitCnt;
		@(negedge iMCLK);
		iCmdValid = 1'b1;
		iCmdWrite = 1'b1;
		iCmdAdrs = adrs;
		iCmdWd = data;
		waitCnt = 0;
		while (!oCmdReady && waitCnt < WAIT_LIMIT)
		begin
			@(negedge iMCLK);
			waitCnt++;
		end
		if (!oCmdReady) timeoutReport("bus never ready for a write");
		@(negedge iMCLK);	// Accepted on the edge just passed
		iCmdValid = 1'b0;
	endtask

	task automatic busRead(input logic [31:0] adrs, output logic [31:0] data);
		int waitCnt;
		int stall;
		@(negedge iMCLK);
		iCmdValid = 1'b1;
		iCmdWrite = 1'b0;
		iCmdAdrs = adrs;
		iCmdWd = '0;
		waitCnt = 0;
		while (!oCmdReady && waitCnt < WAIT_LIMIT)
		begin
			@(negedge iMCLK);
			waitCnt++;
		end
		if (!oCmdReady) timeoutReport("bus never ready for a read");
		@(negedge iMCLK);
		iCmdValid = 1'b0;
		waitCnt = 0;
		while (!oRspValid && waitCnt < WAIT_LIMIT)
		begin
			@(negedge iMCLK);
			waitCnt++;
		end
		if (!oRspValid) timeoutReport("no read response arrived");
		stall = $urandom % 8;		// Back-pressure 0 to 7 cycles
		repeat (stall) @(negedge iMCLK);
		data = oRspRd;
		iRspReady = 1'b1;
		@(negedge iMCLK);
		iRspReady = 1'b0;
	endtask

	// ------------------------------
	// Stimulus
	// ------------------------------
	initial
	begin
		logic [31:0] rd;
		logic [31:0] outVal;
		logic [31:0] dirVal;
		logic [31:0] cmpVal;
		logic [31:0] tmp;
		logic [31:0] c1;
		logic [31:0] c2;
		logic [5:0]  pinVal;
		logic [2:0]  blk;
		logic [2:0]  unmapped [6];
		int unsigned seedVal;
		int startCyc;

		unmapped = '{3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7};
		seedVal = $urandom(51);
		qnARST = 1'b0;
		iCmdValid = 1'b0;
		iCmdWrite = 1'b0;
		iCmdAdrs = '0;
		iCmdWd = '0;
		iRspReady = 1'b0;
		iGpioIn = '0;
		iPllLocked = 1'b0;
		repeat (4) @(negedge iMCLK);
		qnARST = 1'b1;

		// Reset state
		checkEq("ready after reset", {31'b0, oCmdReady}, 32'd1);
		checkEq("rsp valid after reset", {31'b0, oRspValid}, 32'd0);
		checkEq("gpio after reset", {26'b0, oGpio}, 32'd0);
		checkEq("gpio dir after reset", {26'b0, oGpioDir}, 32'd0);
		busRead(csrAdrs(3'd4, TMR_CMP_OFS), rd);
		checkEq("timer compare reset", rd, 32'hFFFF_FFFF);

		// GPIO registers
		outVal = $urandom;
		dirVal = $urandom;
		busWrite(csrAdrs(3'd0, GPIO_OUT_OFS), outVal);
		busWrite(csrAdrs(3'd0, GPIO_DIR_OFS), dirVal);
		@(negedge iMCLK);
		checkEq("gpio pins", {26'b0, oGpio}, {26'b0, outVal[5:0]});
		checkEq("gpio dir pins", {26'b0, oGpioDir}, {26'b0, dirVal[5:0]});
		busRead(csrAdrs(3'd0, GPIO_OUT_OFS), rd);
		checkEq("gpio out readback", rd, {26'b0, outVal[5:0]});
		busRead(csrAdrs(3'd0, GPIO_DIR_OFS), rd);
		checkEq("gpio dir readback", rd, {26'b0, dirVal[5:0]});
		tmp = $urandom;
		pinVal = tmp[5:0];
		iGpioIn = pinVal;
		repeat (3) @(negedge iMCLK);	// Through the synchronizer
		busRead(csrAdrs(3'd0, GPIO_IN_OFS), rd);
		checkEq("gpio in readback", rd, {26'b0, pinVal});

		// Unmapped blocks read zero and swallow writes
		tmp = $urandom;
		blk = unmapped[tmp % 6];
		busRead(csrAdrs(blk, GPIO_OUT_OFS), rd);
		checkEq("unmapped read", rd, 32'd0);
		busWrite(csrAdrs(blk, GPIO_OUT_OFS), ~outVal);
		busWrite(csrAdrs(blk, TMR_CMP_OFS), 32'd5);
		busRead(csrAdrs(3'd0, GPIO_OUT_OFS), rd);
		checkEq("gpio out after unmapped write", rd, {26'b0, outVal[5:0]});
		busRead(csrAdrs(3'd4, TMR_CMP_OFS), rd);
		checkEq("timer cmp after unmapped write", rd, 32'hFFFF_FFFF);

		// ------------------------------
		// Timer match and alt pin 2
		// ------------------------------
		busWrite(csrAdrs(3'd0, GPIO_OUT_OFS), 32'd0);
		busWrite(csrAdrs(3'd0, GPIO_ALT_OFS), 32'd4);
		busWrite(csrAdrs(3'd4, TMR_CTRL_OFS), 32'd2);	// Clear count
		busWrite(csrAdrs(3'd4, TMR_CMP_OFS), 32'd30);
		busWrite(csrAdrs(3'd4, TMR_CTRL_OFS), 32'd1);	// Enable
		startCyc = cycleCnt;
		rd = '0;
		while (!rd[0] && (cycleCnt - startCyc) < 200)
			busRead(csrAdrs(3'd4, TMR_STAT_OFS), rd);
		if (!rd[0]) timeoutReport("timer match flag not set within 200 cycles");
		@(negedge iMCLK);
		checkEq("alt pin 2 on match", {31'b0, oGpio[2]}, 32'd1);
		busRead(csrAdrs(3'd4, TMR_COUNT_OFS), c1);
		checkTrue("timer count at least 30", c1 >= 32'd30);
		busRead(csrAdrs(3'd4, TMR_COUNT_OFS), c2);
		checkTrue("timer count grows", c2 > c1);
		busWrite(csrAdrs(3'd4, TMR_STAT_OFS), 32'd1);	// W1C
		@(negedge iMCLK);
		checkEq("alt pin 2 after clear", {31'b0, oGpio[2]}, 32'd0);
		busRead(csrAdrs(3'd4, TMR_STAT_OFS), rd);
		checkEq("timer flag after clear", rd, 32'd0);
		busWrite(csrAdrs(3'd4, TMR_CTRL_OFS), 32'd0);

		// Heartbeat on pin 1, then PLL lock on pin 0
		busWrite(csrAdrs(3'd0, GPIO_ALT_OFS), 32'd2);
		repeat (2) @(negedge iMCLK);
		hbHighs = 0;
		hbCheck = 1'b1;
		repeat (70) @(negedge iMCLK);
		hbCheck = 1'b0;
		@(negedge iMCLK);
		checkTrue("heartbeat pulses seen", hbHighs >= 3);
		busWrite(csrAdrs(3'd0, GPIO_ALT_OFS), 32'd1);
		@(negedge iMCLK);
		iPllLocked = 1'b1;
		@(negedge iMCLK);
		checkEq("alt pin 0 lock high", {31'b0, oGpio[0]}, 32'd1);
		iPllLocked = 1'b0;
		@(negedge iMCLK);
		checkEq("alt pin 0 lock low", {31'b0, oGpio[0]}, 32'd0);

		// Readback under random back-pressure
		for (int i = 0; i < 4; i++)
		begin
			outVal = $urandom;
			cmpVal = $urandom;
			busWrite(csrAdrs(3'd0, GPIO_OUT_OFS), outVal);
			busWrite(csrAdrs(3'd4, TMR_CMP_OFS), cmpVal);
			busRead(csrAdrs(3'd0, GPIO_OUT_OFS), rd);
			checkEq("stalled gpio readback", rd, {26'b0, outVal[5:0]});
			busRead(csrAdrs(3'd4, TMR_CMP_OFS), rd);
			checkEq("stalled cmp readback", rd, cmpVal);
		end

		repeat (2) @(negedge iMCLK);
		$display("Checks %0d, errors %0d", checkCnt, errCnt);
		if (errCnt == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: logic/usiCoreTop.sv
// USI control plane top
// Bus engine with the GPIO and system timer slaves plus the LED heartbeat
`timescale 1ns/1ns

module usiCoreTop #(
	parameter int pGpioWidth    = 6,
	parameter int pHeartbeatDiv = 25000000
) (
	input  logic                              iMCLK,
	input  logic                              qnARST,
	// Host command
	input  logic                              iCmdValid,
	input  logic                              iCmdWrite,
	input  logic [usiPkg::USI_BUS_WIDTH-1:0]  iCmdAdrs,
	input  logic [usiPkg::USI_BUS_WIDTH-1:0]  iCmdWd,
	output logic                              oCmdReady,
	// Host read response
	output logic                              oRspValid,
	output logic [usiPkg::USI_BUS_WIDTH-1:0]  oRspRd,
	input  logic                              iRspReady,
	// Pins
	output logic [pGpioWidth-1:0]             oGpio,
	output logic [pGpioWidth-1:0]             oGpioDir,
	input  logic [pGpioWidth-1:0]             iGpioIn,
	input  logic                              iPllLocked
);
	import usiPkg::*;

	// ------------------------------
	// Slave side of the bus
	// ------------------------------
	logic                        sGpioSel;
	logic                        sTimerSel;
	logic                        sWe;
	logic [CSR_ACTIVE_WIDTH-1:0] sAdrs;
	logic [USI_BUS_WIDTH-1:0]    sWd;
	logic [USI_BUS_WIDTH-1:0]    sGpioRd;
	logic [USI_BUS_WIDTH-1:0]    sTimerRd;
	logic                        wHeartbeat;
	logic                        wTimerMatch;

	usiBus busEngine (
		.iMCLK(iMCLK),          .qnARST(qnARST),
		.iCmdValid(iCmdValid),  .iCmdWrite(iCmdWrite),
		.iCmdAdrs(iCmdAdrs),    .iCmdWd(iCmdWd),
		.oCmdReady(oCmdReady),
		.oRspValid(oRspValid),  .oRspRd(oRspRd),    .iRspReady(iRspReady),
		.oGpioSel(sGpioSel),    .oTimerSel(sTimerSel),
		.oWe(sWe),              .oAdrs(sAdrs),      .oWd(sWd),
		.iGpioRd(sGpioRd),      .iTimerRd(sTimerRd)
	);

	// Alt bit 0 PLL lock, bit 1 heartbeat, bit 2 timer match
	gpioBlock #(.pGpioWidth(pGpioWidth)) gpio (
		.iMCLK(iMCLK),      .qnARST(qnARST),
		.iSel(sGpioSel),    .iWe(sWe),          .iAdrs(sAdrs),
		.iWd(sWd),          .oRd(sGpioRd),
		.iAltSrc({wTimerMatch, wHeartbeat, iPllLocked}),
		.iGpioIn(iGpioIn),  .oGpio(oGpio),      .oGpioDir(oGpioDir)
	);

	sysTimerBlock sysTimer (
		.iMCLK(iMCLK),      .qnARST(qnARST),
		.iSel(sTimerSel),   .iWe(sWe),          .iAdrs(sAdrs),
		.iWd(sWd),          .oRd(sTimerRd),     .oMatch(wTimerMatch)
	);

	// LED heartbeat
	pulseGen #(.pDivClk(pHeartbeatDiv)) hbPulseGen (
		.iMCLK(iMCLK),      .qnARST(qnARST),    .oPulse(wHeartbeat)
	);

endmodule

// File: logic/pulseGen.sv
// Heartbeat pulse generator
// Wrapping divider that emits a one cycle pulse every pDivClk cycles
`timescale 1ns/1ns

module pulseGen #(
	parameter int pDivClk = 25000000
) (
	input  logic iMCLK,
	input  logic qnARST,
	output logic oPulse
);
	localparam int lpCntWidth = (pDivClk > 1) ? $clog2(pDivClk) : 1;
	localparam logic [lpCntWidth-1:0] lpCntLast = lpCntWidth'(pDivClk - 1);

	logic [lpCntWidth-1:0] rCnt;
	logic                  wWrap;

	assign wWrap = (rCnt == lpCntLast);	// Terminal count

	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			rCnt   <= '0;
			oPulse <= 1'b0;
		end
		else
		begin
			rCnt   <= wWrap ? '0 : rCnt + 1'b1;
			oPulse <= wWrap;		// High one cycle per period
		end
	end

endmodule

// File: logic/sysTimerBlock.sv
// System tick timer slave
// 32 bit free running counter with enable and clear, compare register
// and a sticky match flag cleared by writing 1
`timescale 1ns/1ns

module sysTimerBlock (
	input  logic                                 iMCLK,
	input  logic                                 qnARST,
	// Slave strobes
	input  logic                                 iSel,
	input  logic                                 iWe,
	input  logic [usiPkg::CSR_ACTIVE_WIDTH-1:0]  iAdrs,
	input  logic [usiPkg::USI_BUS_WIDTH-1:0]     iWd,
	output logic [usiPkg::USI_BUS_WIDTH-1:0]     oRd,
	// Match flag out
	output logic                                 oMatch
);
	import usiPkg::*;

	logic                     rEnable;
	logic [USI_BUS_WIDTH-1:0] rCount;
	logic [USI_BUS_WIDTH-1:0] rCmp;
	logic                     rFlag;
	logic                     wCtrlWr;
	logic                     wStatClr;
	logic                     wHit;

	assign wCtrlWr  = iSel && iWe && (iAdrs == TMR_CTRL_OFS);
	assign wStatClr = iSel && iWe && (iAdrs == TMR_STAT_OFS) && iWd[0];
	assign wHit     = rEnable && (rCount == rCmp);	// Compare on the current count

	// ------------------------------
	// Control and compare
	// ------------------------------
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			rEnable <= 1'b0;
			rCmp    <= '1;		// Far away until programmed
		end
		else
		begin
			if (wCtrlWr) rEnable <= iWd[0];
			if (iSel && iWe && (iAdrs == TMR_CMP_OFS)) rCmp <= iWd;
		end
	end

	// Tick counter, clear bit wins over counting
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)                rCount <= '0;
		else if (wCtrlWr && iWd[1]) rCount <= '0;
		else if (rEnable)           rCount <= rCount + 1'b1;
	end

	// Sticky flag, a new match beats the clear
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)       rFlag <= 1'b0;
		else if (wHit)     rFlag <= 1'b1;
		else if (wStatClr) rFlag <= 1'b0;
	end

	// ------------------------------
	// Registered read mux
	// ------------------------------
	always_ff @(posedge iMCLK)
	begin
		if (iSel && !iWe)
		begin
			case (iAdrs)
				TMR_CTRL_OFS:  oRd <= USI_BUS_WIDTH'(rEnable);	// Clear bit reads 0
				TMR_COUNT_OFS: oRd <= rCount;
				TMR_CMP_OFS:   oRd <= rCmp;
				TMR_STAT_OFS:  oRd <= USI_BUS_WIDTH'(rFlag);
				default:       oRd <= '0;
			endcase
		end
	end

	assign oMatch = rFlag;

	// Flag can only rise out of an enabled cycle
	assert property (@(posedge iMCLK) disable iff (!qnARST)
		$rose(rFlag) |-> $past(rEnable))
		else $error("sysTimerBlock match flag set while disabled");

endmodule

// File: logic/gpioBlock.sv
// GPIO slave block
// OUT, DIR and ALT registers on the USI bus, two flop input sync and
// the per pin alternate source mux for the low pins
`timescale 1ns/1ns

module gpioBlock #(
	parameter int pGpioWidth = 6
) (
	input  logic                                 iMCLK,
	input  logic                                 qnARST,
	// Slave strobes
	input  logic                                 iSel,
	input  logic                                 iWe,
	input  logic [usiPkg::CSR_ACTIVE_WIDTH-1:0]  iAdrs,
	input  logic [usiPkg::USI_BUS_WIDTH-1:0]     iWd,
	output logic [usiPkg::USI_BUS_WIDTH-1:0]     oRd,
	// Alternate sources
	input  logic [usiPkg::ALT_SRC_NUM-1:0]       iAltSrc,
	// Pins
	input  logic [pGpioWidth-1:0]                iGpioIn,
	output logic [pGpioWidth-1:0]                oGpio,
	output logic [pGpioWidth-1:0]                oGpioDir
);
	import usiPkg::*;

	logic [pGpioWidth-1:0] rOut;
	logic [pGpioWidth-1:0] rDir;
	logic [pGpioWidth-1:0] rAlt;		// Only the low ALT_SRC_NUM bits steer pins
	logic [pGpioWidth-1:0] rSync1;
	logic [pGpioWidth-1:0] rSync2;	// Stable pin image
	logic                  wWrite;

	assign wWrite = iSel && iWe;

	// ------------------------------
	// CSR write
	// ------------------------------
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			rOut <= '0;
			rDir <= '0;		// All inputs after reset
			rAlt <= '0;
		end
		else if (wWrite)
		begin
			case (iAdrs)
				GPIO_OUT_OFS: rOut <= iWd[pGpioWidth-1:0];
				GPIO_DIR_OFS: rDir <= iWd[pGpioWidth-1:0];
				GPIO_ALT_OFS: rAlt <= iWd[pGpioWidth-1:0];
				default:      ;	// GPIO_IN is read only
			endcase
		end
	end

	// Input synchronizer
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			rSync1 <= '0;
			rSync2 <= '0;
		end
		else
		begin
			rSync1 <= iGpioIn;
			rSync2 <= rSync1;
		end
	end

	// ------------------------------
	// Registered read mux
	// ------------------------------
	always_ff @(posedge iMCLK)
	begin
		if (iSel && !iWe)
		begin
			case (iAdrs)
				GPIO_OUT_OFS: oRd <= USI_BUS_WIDTH'(rOut);
				GPIO_DIR_OFS: oRd <= USI_BUS_WIDTH'(rDir);
				GPIO_ALT_OFS: oRd <= USI_BUS_WIDTH'(rAlt);
				GPIO_IN_OFS:  oRd <= USI_BUS_WIDTH'(rSync2);
				default:      oRd <= '0;
			endcase
		end
	end

	// Pin drive, low pins may take an alternate source
	for (genvar i = 0; i < pGpioWidth; i++)
	begin : genPin
		if (i < ALT_SRC_NUM)
		begin : genAlt
			assign oGpio[i] = rAlt[i] ? iAltSrc[i] : rOut[i];
		end
		else
		begin : genPlain
			assign oGpio[i] = rOut[i];
		end
	end

	assign oGpioDir = rDir;

	// Registers only move on a selected write strobe
	assert property (@(posedge iMCLK) disable iff (!qnARST)
		!$stable({rOut, rDir, rAlt}) |-> $past(iSel && iWe))
		else $error("gpioBlock register changed without a selected write");

endmodule

// File: logic/usiBus.sv
// USI bus engine
// Accepts host commands over valid/ready, decodes the block index and
// issues one cycle registered strobes to the slaves. Reads return
// through a held response register.
`timescale 1ns/1ns

module usiBus (
	input  logic                                 iMCLK,
	input  logic                                 qnARST,
	// Host command
	input  logic                                 iCmdValid,
	input  logic                                 iCmdWrite,
	input  logic [usiPkg::USI_BUS_WIDTH-1:0]     iCmdAdrs,
	input  logic [usiPkg::USI_BUS_WIDTH-1:0]     iCmdWd,
	output logic                                 oCmdReady,
	// Host read response
	output logic                                 oRspValid,
	output logic [usiPkg::USI_BUS_WIDTH-1:0]     oRspRd,
	input  logic                                 iRspReady,
	// Slave strobes
	output logic                                 oGpioSel,
	output logic                                 oTimerSel,
	output logic                                 oWe,
	output logic [usiPkg::CSR_ACTIVE_WIDTH-1:0]  oAdrs,
	output logic [usiPkg::USI_BUS_WIDTH-1:0]     oWd,
	// Slave read words
	input  logic [usiPkg::USI_BUS_WIDTH-1:0]     iGpioRd,
	input  logic [usiPkg::USI_BUS_WIDTH-1:0]     iTimerRd
);
	import usiPkg::*;

	busStateT  rState;
	blockMapT  wCmdBlk;
	blockMapT  rRdBlk;		// Block of the read in flight
	logic      wCmdAccept;
	logic      wHitGpio;
	logic      wHitTimer;

	// ------------------------------
	// Command decode
	// ------------------------------
	assign oCmdReady  = (rState == BUS_IDLE);
	assign wCmdAccept = iCmdValid && oCmdReady;
	assign wCmdBlk    = blockMapT'(iCmdAdrs[CSR_ADRS_WIDTH +: BLOCK_ADRS_WIDTH]);
	assign wHitGpio   = (wCmdBlk == BLK_GPIO);
	assign wHitTimer  = (wCmdBlk == BLK_TIMER);
	assign oRspValid  = (rState == BUS_RESP);

	// Select and write strobes, one cycle per access
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			oGpioSel  <= 1'b0;
			oTimerSel <= 1'b0;
			oWe       <= 1'b0;
		end
		else
		begin
			oGpioSel  <= wCmdAccept && wHitGpio;
			oTimerSel <= wCmdAccept && wHitTimer;
			oWe       <= wCmdAccept && iCmdWrite && (wHitGpio || wHitTimer);	// Unmapped dropped
		end
	end

	// Offset and write data follow the accepted command
	always_ff @(posedge iMCLK)
	begin
		if (wCmdAccept)
		begin
			oAdrs <= iCmdAdrs[CSR_ACTIVE_WIDTH-1:0];
			oWd   <= iCmdWd;
		end
	end

	// ------------------------------
	// Read FSM
	// ------------------------------
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			rState <= BUS_IDLE;
			rRdBlk <= BLK_GPIO;
		end
		else
		begin
			case (rState)
				BUS_IDLE:
				begin
					if (wCmdAccept && !iCmdWrite)
					begin
						rState <= BUS_READ_ADDR;
						rRdBlk <= wCmdBlk;		// Remember target for the mux
					end
				end
				BUS_READ_ADDR: rState <= BUS_READ_DATA;	// Slave registers its word
				BUS_READ_DATA: rState <= BUS_RESP;
				BUS_RESP:      if (iRspReady) rState <= BUS_IDLE;
				default:       rState <= BUS_IDLE;
			endcase
		end
	end

	// Response word capture, unmapped reads give zero
	always_ff @(posedge iMCLK)
	begin
		if (rState == BUS_READ_DATA)
		begin
			case (rRdBlk)
				BLK_GPIO:  oRspRd <= iGpioRd;
				BLK_TIMER: oRspRd <= iTimerRd;
				default:   oRspRd <= '0;
			endcase
		end
	end

	// Stalled response holds its word
	assert property (@(posedge iMCLK) disable iff (!qnARST)
		(oRspValid && !iRspReady) |=> (oRspValid && $stable(oRspRd)))
		else $error("usiBus response changed while stalled");

	// Read blocks the host until its response is up
	assert property (@(posedge iMCLK) disable iff (!qnARST)
		(wCmdAccept && !iCmdWrite) |=> !oCmdReady [*2] ##1 (oRspValid && !oCmdReady))
		else $error("usiBus accepted a command during a pending read");

endmodule

// File: logic/usiPkg.sv
// USI register bus shared definitions
// Bus widths, block address map, CSR offsets and bus FSM states
package usiPkg;

	// ------------------------------
	// Bus geometry
	// ------------------------------
	localparam int USI_BUS_WIDTH    = 32;	// Data and address width
	localparam int CSR_ADRS_WIDTH   = 16;	// Per block CSR space
	localparam int BLOCK_ADRS_WIDTH = 3;	// Block index above the CSR space
	localparam int CSR_ACTIVE_WIDTH = 8;	// Offset bits the slaves decode

	// Block index map, holes are unmapped
	typedef enum logic [BLOCK_ADRS_WIDTH-1:0]
	{
		BLK_GPIO  = 3'h0,
		BLK_TIMER = 3'h4
	} blockMapT;

	// ------------------------------
	// GPIO CSR offsets
	// ------------------------------
	localparam logic [CSR_ACTIVE_WIDTH-1:0] GPIO_OUT_OFS = 8'h00;	// Output level
	localparam logic [CSR_ACTIVE_WIDTH-1:0] GPIO_DIR_OFS = 8'h04;	// 1 = output
	localparam logic [CSR_ACTIVE_WIDTH-1:0] GPIO_ALT_OFS = 8'h08;	// Alternate enables
	localparam logic [CSR_ACTIVE_WIDTH-1:0] GPIO_IN_OFS  = 8'h0C;	// Synced pin state, RO

	// ------------------------------
	// Timer CSR offsets
	// ------------------------------
	localparam logic [CSR_ACTIVE_WIDTH-1:0] TMR_CTRL_OFS  = 8'h00;	// b0 enable, b1 clear
	localparam logic [CSR_ACTIVE_WIDTH-1:0] TMR_COUNT_OFS = 8'h04;	// Tick count, RO
	localparam logic [CSR_ACTIVE_WIDTH-1:0] TMR_CMP_OFS   = 8'h08;	// Compare value
	localparam logic [CSR_ACTIVE_WIDTH-1:0] TMR_STAT_OFS  = 8'h0C;	// b0 match, W1C

	// Alternate sources: PLL lock, heartbeat, timer match
	localparam int ALT_SRC_NUM = 3;

	// Bus engine FSM
	typedef enum logic [1:0]
	{
		BUS_IDLE,
		BUS_READ_ADDR,		// Slave strobe cycle
		BUS_READ_DATA,		// Slave word valid, capture
		BUS_RESP			// Waiting for host handshake
	} busStateT;

endpackage
